/* source/gate_settings.svh */
////////////////////////////////////////////////////////////////////////////
// Fixed-point widths for the input gate datapath
// Included by the package and by every RTL module
////////////////////////////////////////////////////////////////////////////

`ifndef GATE_SETTINGS_SVH
`define GATE_SETTINGS_SVH

// Operand and result width in Q8.8
`define GATE_DATA_WIDTH 16

// Fraction bits so 1.0 is 256
`define GATE_FRAC_BITS 8

// Accumulator width for the longest dot products
`define GATE_ACC_WIDTH 40

// Size inputs run from 1 to 15
`define GATE_SIZE_WIDTH 4

`endif

/* source/gate_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared states, opcodes and stage payloads of the input gate
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "gate_settings.svh"

package gate_pkg;

  // Sequencer walk through one element
  typedef enum logic [2:0] {
    PHASE_IDLE,  // Waiting for start
    PHASE_W_X,   // W(l)·x
    PHASE_K_R,   // K(l)·r
    PHASE_U_H,   // U(l)·h
    PHASE_BIAS   // b(l) closes the element
  } gate_phase_e;

  // MAC opcodes
  typedef enum logic [1:0] {
    TERM_FIRST,       // Load product
    TERM_ACCUMULATE,  // Add product
    TERM_BIAS         // Rescale, add bias, emit
  } term_op_e;

  // One issued term, sequencer to MAC
  typedef struct packed {
    term_op_e                           op;
    logic signed [`GATE_DATA_WIDTH-1:0] operand_a;
    logic signed [`GATE_DATA_WIDTH-1:0] operand_b;
    logic signed [`GATE_DATA_WIDTH-1:0] bias;
    logic                               last_element;  // Bias term of final l
  } term_t;

  // Vector sizes captured at start
  typedef struct packed {
    logic [`GATE_SIZE_WIDTH-1:0] size_x;
    logic [`GATE_SIZE_WIDTH-1:0] size_k;
    logic [`GATE_SIZE_WIDTH-1:0] size_l;
  } gate_sizes_t;

  // Saturated pre-activation, MAC to logistic
  typedef struct packed {
    logic signed [`GATE_DATA_WIDTH-1:0] value;
    logic                               last_element;
  } preact_t;

endpackage

`default_nettype wire

/* source/gate_operand_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Input side of the gate. Requests operand pairs phase by phase for each l
// and hands every answered pair to the MAC as one term
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "gate_settings.svh"

module gate_operand_sequencer (
  input  logic                               CLK,
  input  logic                               RST,

  input  logic                               start,
  input  gate_pkg::gate_sizes_t              sizes,

  // Operand requests and answers
  output logic                               w_x_request,
  output logic                               k_r_request,
  output logic                               u_h_request,
  output logic                               b_request,
  input  logic                               w_x_enable,
  input  logic                               k_r_enable,
  input  logic                               u_h_enable,
  input  logic                               b_enable,

  input  logic signed [`GATE_DATA_WIDTH-1:0] w_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] x_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] k_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] r_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] u_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] h_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] b_in,

  output gate_pkg::term_t                    term,
  output logic                               term_valid
);

  import gate_pkg::*;

  gate_phase_e                        phase;
  gate_phase_e                        next_phase;
  gate_sizes_t                        sizes_q;       // Held for the whole run
  logic        [`GATE_SIZE_WIDTH-1:0] element_cnt;   // Current l
  logic        [`GATE_SIZE_WIDTH-1:0] column_cnt;    // Index inside a phase
  logic        [`GATE_SIZE_WIDTH-1:0] phase_size;
  logic                               phase_enable;  // Answer of the open request
  logic                               last_column;
  logic                               last_row;
  logic                               advance;       // New request goes out
  logic signed [`GATE_DATA_WIDTH-1:0] operand_a;
  logic signed [`GATE_DATA_WIDTH-1:0] operand_b;
  term_t                              term_next;

  ////////////////////////////////////////////////////////////////////////////
  // Phase decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    phase_size   = '0;
    phase_enable = 1'b0;
    operand_a    = '0;
    operand_b    = '0;
    case (phase)
      PHASE_W_X: begin
        phase_size   = sizes_q.size_x;
        phase_enable = w_x_enable;
        operand_a    = w_in;
        operand_b    = x_in;
      end
      PHASE_K_R: begin
        phase_size   = sizes_q.size_k;
        phase_enable = k_r_enable;
        operand_a    = k_in;
        operand_b    = r_in;
      end
      PHASE_U_H: begin
        phase_size   = sizes_q.size_l;  // U is square
        phase_enable = u_h_enable;
        operand_a    = u_in;
        operand_b    = h_in;
      end
      PHASE_BIAS: phase_enable = b_enable;
      default: phase_enable = 1'b0;  // Idle ignores stray strobes
    endcase
  end

  assign last_column = (column_cnt == phase_size - 1'b1);
  assign last_row    = (element_cnt == sizes_q.size_l - 1'b1);

  // Where the walk goes on this cycle's answer
  always_comb begin
    next_phase = phase;
    advance    = 1'b0;
    case (phase)
      PHASE_IDLE: begin
        if (start) begin
          next_phase = PHASE_W_X;
          advance    = 1'b1;
        end
      end
      PHASE_W_X: begin
        advance = phase_enable;
        if (phase_enable && last_column) next_phase = PHASE_K_R;
      end
      PHASE_K_R: begin
        advance = phase_enable;
        if (phase_enable && last_column) next_phase = PHASE_U_H;
      end
      PHASE_U_H: begin
        advance = phase_enable;
        if (phase_enable && last_column) next_phase = PHASE_BIAS;
      end
      PHASE_BIAS: begin
        if (phase_enable) begin
          advance    = !last_row;  // Nothing to ask for after final l
          next_phase = last_row ? PHASE_IDLE : PHASE_W_X;
        end
      end
      default: next_phase = PHASE_IDLE;
    endcase
  end

  // Term built from the answer in flight
  always_comb begin
    term_next.op = TERM_ACCUMULATE;
    if (phase == PHASE_BIAS) begin
      term_next.op = TERM_BIAS;
    end else if (phase == PHASE_W_X && column_cnt == '0) begin
      term_next.op = TERM_FIRST;  // Opens a fresh l
    end
    term_next.operand_a    = operand_a;
    term_next.operand_b    = operand_b;
    term_next.bias         = b_in;
    term_next.last_element = (phase == PHASE_BIAS) && last_row;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase       <= PHASE_IDLE;
      element_cnt <= '0;
      column_cnt  <= '0;
      w_x_request <= 1'b0;
      k_r_request <= 1'b0;
      u_h_request <= 1'b0;
      b_request   <= 1'b0;
      term_valid  <= 1'b0;
    end else begin
      phase       <= next_phase;
      term_valid  <= phase_enable;  // Issue one cycle after the answer
      // Single-cycle request pulses
      w_x_request <= advance && (next_phase == PHASE_W_X);
      k_r_request <= advance && (next_phase == PHASE_K_R);
      u_h_request <= advance && (next_phase == PHASE_U_H);
      b_request   <= advance && (next_phase == PHASE_BIAS);

      if (advance) begin
        if (phase == PHASE_IDLE || next_phase != phase) begin
          column_cnt <= '0;
        end else begin
          column_cnt <= column_cnt + 1'b1;
        end
      end

      if (phase == PHASE_IDLE) begin
        element_cnt <= '0;
      end else if (phase == PHASE_BIAS && phase_enable && !last_row) begin
        element_cnt <= element_cnt + 1'b1;
      end
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (phase == PHASE_IDLE && start) sizes_q <= sizes;
    if (phase_enable) term <= term_next;
  end

endmodule

`default_nettype wire

/* source/gate_mac_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Processing part. Accumulates products for one l, then rescales to Q8.8,
// adds the bias and saturates the pre-activation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "gate_settings.svh"

module gate_mac_unit (
  input  logic              CLK,
  input  logic              RST,

  input  gate_pkg::term_t   term,
  input  logic              term_valid,

  output gate_pkg::preact_t preact,
  output logic              preact_valid
);

  import gate_pkg::*;

  // Signed 16-bit limits at accumulator width
  localparam logic signed [`GATE_ACC_WIDTH-1:0] sat_max = 2 ** (`GATE_DATA_WIDTH - 1) - 1;
  localparam logic signed [`GATE_ACC_WIDTH-1:0] sat_min = -(2 ** (`GATE_DATA_WIDTH - 1));

  logic signed [`GATE_ACC_WIDTH-1:0]    acc;
  logic signed [2*`GATE_DATA_WIDTH-1:0] product;      // Q16.16
  logic signed [`GATE_ACC_WIDTH-1:0]    product_ext;
  logic signed [`GATE_ACC_WIDTH-1:0]    scaled;       // Back to Q8.8
  logic signed [`GATE_ACC_WIDTH-1:0]    biased;
  logic signed [`GATE_DATA_WIDTH-1:0]   saturated;

  always_comb begin
    product     = $signed(term.operand_a) * $signed(term.operand_b);
    product_ext = product;                 // Sign extend
    scaled      = acc >>> `GATE_FRAC_BITS;  // Floor toward minus infinity
    biased      = scaled + $signed(term.bias);
    if (biased > sat_max) begin
      saturated = sat_max[`GATE_DATA_WIDTH-1:0];
    end else if (biased < sat_min) begin
      saturated = sat_min[`GATE_DATA_WIDTH-1:0];
    end else begin
      saturated = biased[`GATE_DATA_WIDTH-1:0];
    end
  end

  // Accumulator, always reloaded by TERM_FIRST
  always_ff @(posedge CLK) begin
    if (term_valid) begin
      case (term.op)
        TERM_FIRST:      acc <= product_ext;
        TERM_ACCUMULATE: acc <= acc + product_ext;
        default:         acc <= acc;  // Bias term only reads
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (term_valid && term.op == TERM_BIAS) begin
      preact.value        <= saturated;
      preact.last_element <= term.last_element;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      preact_valid <= 1'b0;
    end else begin
      preact_valid <= term_valid && (term.op == TERM_BIAS);
    end
  end

endmodule

`default_nettype wire

/* source/gate_logistic_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Output side. Hard logistic 0.5 + z/4 clamped to [0, 1] in Q8.8
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "gate_settings.svh"

module gate_logistic_unit (
  input  logic                               CLK,
  input  logic                               RST,

  input  gate_pkg::preact_t                  preact,
  input  logic                               preact_valid,

  output logic signed [`GATE_DATA_WIDTH-1:0] i_out,
  output logic                               i_out_enable,
  output logic                               ready
);

  localparam logic signed [`GATE_DATA_WIDTH:0] half = 2 ** (`GATE_FRAC_BITS - 1);  // 0.5
  localparam logic signed [`GATE_DATA_WIDTH:0] one  = 2 ** `GATE_FRAC_BITS;        // 1.0

  logic signed [`GATE_DATA_WIDTH-1:0] quarter;   // z/4
  logic signed [`GATE_DATA_WIDTH:0]   linear;    // One guard bit
  logic signed [`GATE_DATA_WIDTH-1:0] squashed;

  always_comb begin
    quarter = $signed(preact.value) >>> 2;
    linear  = quarter + half;
    if (linear < 0) begin
      squashed = '0;
    end else if (linear > one) begin
      squashed = one[`GATE_DATA_WIDTH-1:0];
    end else begin
      squashed = linear[`GATE_DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      i_out        <= '0;
      i_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      i_out_enable <= preact_valid;
      ready        <= preact_valid && preact.last_element;  // With final output
      if (preact_valid) i_out <= squashed;
    end
  end

endmodule

`default_nettype wire

/* source/input_gate_vector.sv */
////////////////////////////////////////////////////////////////////////////
// Input gate i(l) = logistic(W·x + K·r + U·h + b) over streamed operands
// Sequencer feeds the MAC, MAC feeds the hard logistic
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "gate_settings.svh"

module input_gate_vector (
  input  logic                               CLK,
  input  logic                               RST,

  // Control
  input  logic                               start,
  input  gate_pkg::gate_sizes_t              sizes,

  // Operand requests
  output logic                               w_x_request,
  output logic                               k_r_request,
  output logic                               u_h_request,
  output logic                               b_request,

  // Answer strobes
  input  logic                               w_x_enable,
  input  logic                               k_r_enable,
  input  logic                               u_h_enable,
  input  logic                               b_enable,

  // Operand data
  input  logic signed [`GATE_DATA_WIDTH-1:0] w_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] x_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] k_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] r_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] u_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] h_in,
  input  logic signed [`GATE_DATA_WIDTH-1:0] b_in,

  // Result stream
  output logic signed [`GATE_DATA_WIDTH-1:0] i_out,
  output logic                               i_out_enable,
  output logic                               ready
);

  import gate_pkg::*;

  term_t   term;          // Sequencer to MAC
  logic    term_valid;
  preact_t preact;        // MAC to logistic
  logic    preact_valid;

  gate_operand_sequencer gate_operand_sequencer_i (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .sizes      (sizes),
    .w_x_request(w_x_request),
    .k_r_request(k_r_request),
    .u_h_request(u_h_request),
    .b_request  (b_request),
    .w_x_enable (w_x_enable),
    .k_r_enable (k_r_enable),
    .u_h_enable (u_h_enable),
    .b_enable   (b_enable),
    .w_in       (w_in),
    .x_in       (x_in),
    .k_in       (k_in),
    .r_in       (r_in),
    .u_in       (u_in),
    .h_in       (h_in),
    .b_in       (b_in),
    .term       (term),
    .term_valid (term_valid)
  );

  gate_mac_unit gate_mac_unit_i (
    .CLK         (CLK),
    .RST         (RST),
    .term        (term),
    .term_valid  (term_valid),
    .preact      (preact),
    .preact_valid(preact_valid)
  );

  gate_logistic_unit gate_logistic_unit_i (
    .CLK         (CLK),
    .RST         (RST),
    .preact      (preact),
    .preact_valid(preact_valid),
    .i_out       (i_out),
    .i_out_enable(i_out_enable),
    .ready       (ready)
  );

endmodule

`default_nettype wire

/* verification/gate_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source, reset held for a set number of cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gate_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 3
) (
  output logic CLK,
  output logic RST
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(period_ns / 2) CLK = ~CLK;
  end

  // Reset drops just after an edge, like the other inputs
  initial begin
    RST = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    #1 RST = 1'b0;
  end

endmodule

`default_nettype wire

/* verification/input_gate_vector_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Table-driven testbench for the input gate that answers operand requests
// and checks every i_out against a fixed-point model of the gate
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "gate_settings.svh"

module input_gate_vector_tb;

  import gate_pkg::*;

  typedef logic [`GATE_DATA_WIDTH-1:0] word_t;

  // One table row of stimulus and expected outputs
  typedef struct packed {
    gate_sizes_t      sizes;
    logic             random_delay;  // 0 answers in the request cycle
    logic             mid_start;     // Extra start pulse during the run
    word_t [3:0][3:0] w;             // [l][j]
    word_t [3:0]      x;
    word_t [3:0][3:0] k;
    word_t [3:0]      r;
    word_t [3:0][3:0] u;
    word_t [3:0]      h;
    word_t [3:0]      b;
    word_t [3:0]      expected;      // i_out per l
  } gate_case_t;

  localparam int num_cases = 6;

  logic                               CLK, RST;
  logic                               start;
  gate_sizes_t                        sizes;
  logic                               w_x_request, k_r_request, u_h_request, b_request;
  logic                               w_x_enable, k_r_enable, u_h_enable, b_enable;
  logic signed [`GATE_DATA_WIDTH-1:0] w_in, x_in, k_in, r_in, u_in, h_in, b_in;
  logic signed [`GATE_DATA_WIDTH-1:0] i_out;
  logic                               i_out_enable, ready;

  gate_case_t  cases [num_cases];
  gate_case_t  cur;                        // Case being applied
  integer      seed;
  int          errors, check_count, cycle_count, timeout_cycles;
  bit          table_ready;
  gate_phase_e exp_phase;                  // Next request kind
  gate_phase_e pend_kind;                  // Open request
  int          exp_col, exp_l, wait_left, req_count, out_idx, ready_count;
  bit          pending, run_done;
  word_t       pend_a, pend_b;
  int          b_cycles [$];               // Cycle of each bias answer

  gate_clock_gen #(.period_ns(40), .reset_cycles(3)) gate_clock_gen_i (.CLK(CLK), .RST(RST));

  input_gate_vector input_gate_vector_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////////////////////////////////////////

  // Q8.8 dot products, floor rescale, 16-bit clamp, then 0.5 + z/4 in [0, 1]
  function automatic word_t expected_gate(input gate_case_t c, input int l);
    longint acc;
    longint pre;
    longint gate;
    int     j;
    acc = 0;
    for (j = 0; j < c.sizes.size_x; j++) acc += longint'($signed(c.w[l][j])) * $signed(c.x[j]);
    for (j = 0; j < c.sizes.size_k; j++) acc += longint'($signed(c.k[l][j])) * $signed(c.r[j]);
    for (j = 0; j < c.sizes.size_l; j++) acc += longint'($signed(c.u[l][j])) * $signed(c.h[j]);
    pre = (acc >>> `GATE_FRAC_BITS) + longint'($signed(c.b[l]));
    if (pre > (longint'(1) << (`GATE_DATA_WIDTH - 1)) - 1) pre = (1 << (`GATE_DATA_WIDTH - 1)) - 1;
    if (pre < -(longint'(1) << (`GATE_DATA_WIDTH - 1))) pre = -(1 << (`GATE_DATA_WIDTH - 1));
    gate = (pre >>> 2) + (1 << (`GATE_FRAC_BITS - 1));
    if (gate < 0) gate = 0;
    if (gate > (1 << `GATE_FRAC_BITS)) gate = 1 << `GATE_FRAC_BITS;
    return word_t'(gate);
  endfunction

  function automatic int expected_requests(input gate_case_t c);
    int sx;
    int sk;
    int sl;
    sx = c.sizes.size_x;
    sk = c.sizes.size_k;
    sl = c.sizes.size_l;
    return sl * (sx + sk + sl + 1);  // Three dot products and a bias per l
  endfunction

  function automatic word_t random_operand();
    return word_t'($random(seed) % 160);  // About +-0.6
  endfunction

  function automatic gate_case_t blank_case(input int sx, input int sk, input int sl);
    gate_case_t c;
    c = '0;
    c.sizes.size_x = sx;
    c.sizes.size_k = sk;
    c.sizes.size_l = sl;
    return c;
  endfunction

  task automatic fill_random(inout gate_case_t c);
    int l;
    int j;
    for (l = 0; l < c.sizes.size_l; l++) begin
      c.b[l] = random_operand();
      c.h[l] = random_operand();
      for (j = 0; j < c.sizes.size_x; j++) c.w[l][j] = random_operand();
      for (j = 0; j < c.sizes.size_k; j++) c.k[l][j] = random_operand();
      for (j = 0; j < c.sizes.size_l; j++) c.u[l][j] = random_operand();
    end
    for (j = 0; j < c.sizes.size_x; j++) c.x[j] = random_operand();
    for (j = 0; j < c.sizes.size_k; j++) c.r[j] = random_operand();
  endtask

  task automatic store_case(input int n, input gate_case_t c);
    int l;
    for (l = 0; l < c.sizes.size_l; l++) c.expected[l] = expected_gate(c, l);
    cases[n] = c;
  endtask

  task automatic build_table();
    gate_case_t c;
    c = blank_case(1, 1, 1);         // Mixed signs and a floor in the rescale
    c.w[0][0] = -3;
    c.x[0]    = 5;
    c.k[0][0] = 256;
    c.r[0]    = 96;
    c.u[0][0] = 64;
    c.h[0]    = -200;
    c.b[0]    = -7;
    store_case(0, c);
    c = blank_case(1, 1, 1);         // Pre-activation pinned at +32767
    c.w[0][0] = 16'h7fff;
    c.x[0]    = 16'h7fff;
    c.k[0][0] = 16'h7fff;
    c.r[0]    = 16'h7fff;
    c.b[0]    = 16'h7fff;
    store_case(1, c);
    c = blank_case(1, 1, 2);         // Pinned at -32768 and then a mild negative
    c.w[0][0] = 16'h8000;
    c.x[0]    = 16'h7fff;
    c.b[0]    = 16'h8000;
    c.b[1]    = -600;
    store_case(2, c);
    c = blank_case(4, 4, 4);
    fill_random(c);
    c.random_delay = 1'b1;
    store_case(3, c);
    c = blank_case(3, 2, 4);
    fill_random(c);
    c.random_delay = 1'b1;
    store_case(4, c);
    c = blank_case(2, 3, 2);         // Immediate answers and a stray start mid-run
    fill_random(c);
    c.mid_start = 1'b1;
    store_case(5, c);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and operand responder
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input longint expected, input longint actual);
    errors++;
    $display("Fail at %0t: %s expected %0d got %0d", $time, name, expected, actual);
  endtask

  task automatic report_problem(input string text);
    errors++;
    $display("Error at %0t: %s", $time, text);
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;                              // Outputs settled and inputs change here
    cycle_count++;
  endtask

  task automatic check_idle(input bit out_zero);
    check_count++;
    if (w_x_request || k_r_request || u_h_request || b_request) begin
      report_problem("operand request while idle");
    end
    if (i_out_enable || ready) report_problem("i_out_enable or ready while idle");
    if (out_zero && i_out !== '0) report_mismatch("i_out", 0, i_out);
  endtask

  task automatic check_outputs();
    int issued;
    if (ready) begin
      ready_count++;
      if (!i_out_enable || out_idx != cur.sizes.size_l - 1) begin
        report_problem("ready pulsed without the final output");
      end
    end
    if (i_out_enable) begin
      check_count++;
      if (i_out !== cur.expected[out_idx]) begin
        report_mismatch("i_out", $signed(cur.expected[out_idx]), i_out);
      end
      if (b_cycles.size() == 0) begin
        report_problem("output without a bias answer before it");
      end else begin
        issued = b_cycles.pop_front();
        if (cycle_count - issued != 3) begin
          report_mismatch("i_out_enable latency", 3, cycle_count - issued);
        end
      end
      out_idx++;
    end
  endtask

  // Checks request order, picks the operand pair and advances the walk
  task automatic take_request();
    gate_phase_e got;
    int          limit;
    if (w_x_request) got = PHASE_W_X;
    else if (k_r_request) got = PHASE_K_R;
    else if (u_h_request) got = PHASE_U_H;
    else got = PHASE_BIAS;
    req_count++;
    check_count++;
    if (run_done) begin
      report_problem("operand request after the final bias");
    end else if (got != exp_phase) begin
      report_problem($sformatf("%s request while %s was due", got.name(), exp_phase.name()));
    end
    pending   = 1'b1;
    pend_kind = got;
    wait_left = cur.random_delay ? ($unsigned($random(seed)) % 4) : 0;
    case (exp_phase)
      PHASE_W_X: begin
        pend_a = cur.w[exp_l][exp_col];
        pend_b = cur.x[exp_col];
        limit  = cur.sizes.size_x;
      end
      PHASE_K_R: begin
        pend_a = cur.k[exp_l][exp_col];
        pend_b = cur.r[exp_col];
        limit  = cur.sizes.size_k;
      end
      PHASE_U_H: begin
        pend_a = cur.u[exp_l][exp_col];
        pend_b = cur.h[exp_col];
        limit  = cur.sizes.size_l;   // U is square
      end
      default: begin
        pend_a = cur.b[exp_l];
        pend_b = '0;
        limit  = 1;
      end
    endcase
    exp_col++;
    if (exp_col == limit) begin
      exp_col = 0;
      case (exp_phase)
        PHASE_W_X: exp_phase = PHASE_K_R;
        PHASE_K_R: exp_phase = PHASE_U_H;
        PHASE_U_H: exp_phase = PHASE_BIAS;
        default: begin
          exp_phase = PHASE_W_X;     // Next l
          exp_l++;
          run_done  = (exp_l == cur.sizes.size_l);
        end
      endcase
    end
  endtask

  task automatic answer();
    case (pend_kind)
      PHASE_W_X: begin
        w_x_enable = 1'b1;
        w_in       = pend_a;
        x_in       = pend_b;
      end
      PHASE_K_R: begin
        k_r_enable = 1'b1;
        k_in       = pend_a;
        r_in       = pend_b;
      end
      PHASE_U_H: begin
        u_h_enable = 1'b1;
        u_in       = pend_a;
        h_in       = pend_b;
      end
      default: begin
        b_enable = 1'b1;
        b_in     = pend_a;
        b_cycles.push_back(cycle_count);
      end
    endcase
  endtask

  task automatic respond();
    int active;
    active = w_x_request + k_r_request + u_h_request + b_request;
    if (active > 1) report_problem("several operand requests in one cycle");
    if (active != 0) begin
      if (pending) report_problem("request while another is outstanding");
      take_request();
    end
    if (pending) begin
      if (wait_left == 0) begin
        answer();
        pending = 1'b0;
      end else begin
        wait_left--;
      end
    end
  endtask

  task automatic service_cycle();
    w_x_enable = 1'b0;               // Strobes last one cycle
    k_r_enable = 1'b0;
    u_h_enable = 1'b0;
    b_enable   = 1'b0;
    check_outputs();
    respond();
  endtask

  task automatic run_case(input int idx);
    int local_cycle;
    cur         = cases[idx];
    exp_phase   = PHASE_W_X;
    exp_col     = 0;
    exp_l       = 0;
    run_done    = 1'b0;
    pending     = 1'b0;
    out_idx     = 0;
    req_count   = 0;
    ready_count = 0;
    local_cycle = 0;
    b_cycles.delete();
    next_cycle();
    start = 1'b1;
    sizes = cur.sizes;
    service_cycle();
    while (out_idx < cur.sizes.size_l) begin
      next_cycle();
      local_cycle++;
      start = 1'b0;
      sizes = cur.sizes;
      if (cur.mid_start && local_cycle == 3) begin
        start = 1'b1;                // Ignored along with its sizes
        sizes = ~cur.sizes;
      end
      service_cycle();
    end
    start = 1'b0;
    check_count++;
    if (req_count != expected_requests(cur)) begin
      report_mismatch("request count", expected_requests(cur), req_count);
    end
    if (!run_done) report_problem("outputs finished before the final bias request");
    if (ready_count != 1) report_mismatch("ready pulses", 1, ready_count);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    start       = 1'b0;
    sizes       = '0;
    w_x_enable  = 1'b0;
    k_r_enable  = 1'b0;
    u_h_enable  = 1'b0;
    b_enable    = 1'b0;
    w_in        = '0;
    x_in        = '0;
    k_in        = '0;
    r_in        = '0;
    u_in        = '0;
    h_in        = '0;
    b_in        = '0;
    errors      = 0;
    check_count = 0;
    cycle_count = 0;
    seed        = 32'h86ae;
    build_table();
    timeout_cycles = 100;            // Reset and idle checks
    for (int n = 0; n < num_cases; n++) begin
      timeout_cycles += 64 * expected_requests(cases[n]);
    end
    table_ready = 1'b1;
    wait (RST === 1'b0);
    repeat (4) begin
      next_cycle();
      check_idle(1'b1);
    end
    for (int n = 0; n < num_cases; n++) run_case(n);  // Back to back
    repeat (4) begin
      next_cycle();
      check_idle(1'b0);              // No trailing outputs
    end
    $display("Checks: %0d, errors: %0d", check_count, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (timeout_cycles) @(posedge CLK);
    $display("Timeout after %0d cycles, the DUT stopped making progress", timeout_cycles);
    $display("Checks: %0d, errors: %0d", check_count, errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+source
source/gate_pkg.sv
source/gate_operand_sequencer.sv
source/gate_mac_unit.sv
source/gate_logistic_unit.sv
source/input_gate_vector.sv
verification/gate_clock_gen.sv
verification/input_gate_vector_tb.sv

/* Bender.yml */
package:
  name: input_gate_vector

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/gate_pkg.sv
      - source/gate_operand_sequencer.sv
      - source/gate_mac_unit.sv
      - source/gate_logistic_unit.sv
      - source/input_gate_vector.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/gate_clock_gen.sv
      - verification/input_gate_vector_tb.sv
